// File: compile.f
hw/rsa_pkg.sv
hw/avm_pkg.sv
hw/rsa_prep.sv
hw/rsa_mont.sv
hw/rsa_core.sv
hw/rsa_wrapper.sv
hw/rsa_system.sv
dv/tb_uart_model.sv
dv/tb_rsa_system.sv

// File: dv/tb_rsa_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_system;

    localparam int KEY_BITS     = 256;
    localparam int OUT_BYTES    = KEY_BITS / 8 - 1;
    localparam int BYTE_TIMEOUT = 200000;
    localparam logic [255:0] N0 =
        256'hD4C1_8E93_5B27_A6F0_3C19_7E5D_2A84_B6C3_9F01_E472_58AD_3B96_C70E_14F2_8A65_D39B;
    localparam logic [255:0] N1 =
        256'hB7E2_4A19_C05D_6F83_21BE_9A47_D3C8_0F65_7E1A_94B2_5C3D_E806_1F7B_A2C9_4D50_6E8F;

    logic         avm_clk;
    logic         avm_rst;
    logic [4:0]   avm_address;
    logic         avm_read;
    logic [31:0]  avm_readdata;
    logic         avm_write;
    logic [31:0]  avm_writedata;
    logic         avm_waitrequest;
    int           errors;
    int           checks;
    bit           aborted; // Set on a timeout so later tests are skipped.
    logic [255:0] msg_d;
    logic [255:0] msg_enc;

    rsa_system #(.KEY_BITS(KEY_BITS)) u_rsa_system (
        .avm_clk        (avm_clk),
        .avm_rst        (avm_rst),
        .avm_address    (avm_address),
        .avm_read       (avm_read),
        .avm_readdata   (avm_readdata),
        .avm_write      (avm_write),
        .avm_writedata  (avm_writedata),
        .avm_waitrequest(avm_waitrequest)
    );

    tb_uart_model u_uart (
        .avm_clk    (avm_clk),
        .address    (avm_address),
        .read       (avm_read),
        .write      (avm_write),
        .writedata  (avm_writedata),
        .readdata   (avm_readdata),
        .waitrequest(avm_waitrequest)
    );

    initial begin
        avm_clk = 1'b0;
        forever #5 avm_clk = ~avm_clk;
    end

    task automatic wait_cycle();
        @(posedge avm_clk);
        #2;
    endtask

    task automatic expect_equal(input string name, input logic [255:0] expected,
                                input logic [255:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // Shift-and-add product, kept below n after every step.
    function automatic logic [255:0] mod_mul(input logic [255:0] a, input logic [255:0] b,
                                             input logic [255:0] n);
        logic [257:0] r;
        logic [257:0] ax;
        logic [257:0] nx;
        int i;
        r  = '0;
        ax = {2'b00, a};
        nx = {2'b00, n};
        for (i = 255; i >= 0; i--) begin
            r = r << 1;
            if (r >= nx) r = r - nx;
            if (b[i]) begin
                r = r + ax;
                if (r >= nx) r = r - nx;
            end
        end
        return r[255:0];
    endfunction

    function automatic logic [255:0] mod_exp(input logic [255:0] base, input logic [255:0] e,
                                             input logic [255:0] n);
        logic [255:0] acc;
        logic [255:0] sq;
        int i;
        acc = 256'd1;
        sq  = base;
        for (i = 0; i < 256; i++) begin
            if (e[i]) acc = mod_mul(acc, sq, n);
            sq = mod_mul(sq, sq, n);
        end
        return acc;
    endfunction

    // Top bit cleared, so the value stays below any modulus used here.
    function automatic logic [255:0] random_below_top();
        logic [255:0] v;
        v = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
        v[255] = 1'b0;
        return v;
    endfunction

    task automatic push_operand(input logic [255:0] value);
        int i;
        for (i = 31; i >= 0; i--) begin
            u_uart.push_byte(value[8*i +: 8]);
        end
    endtask

    task automatic send_message(input logic [255:0] n, input logic [255:0] d,
                                input logic [255:0] enc);
        push_operand(n);
        push_operand(d);
        push_operand(enc);
    endtask

    task automatic collect_result(input string name, input logic [255:0] expected);
        logic [7:0] got;
        int waited;
        int k;
        for (k = 0; k < OUT_BYTES; k++) begin
            if (!aborted) begin
                waited = 0;
                while (u_uart.tx_count() == 0 && waited < BYTE_TIMEOUT) begin
                    wait_cycle();
                    waited++;
                end
                if (u_uart.tx_count() == 0) begin
                    errors++;
                    aborted = 1'b1;
                    $display("%s timed out waiting for output byte %0d", name, k);
                end else begin
                    u_uart.take_byte(got);
                    expect_equal(name, 256'(expected[8*(OUT_BYTES-1-k) +: 8]), 256'(got));
                end
            end
        end
    endtask

    // Nothing extra on TX, every input byte consumed, no protocol slip.
    task automatic check_clean(input string name);
        if (!aborted) begin
            repeat (20) wait_cycle();
            expect_equal({name, " extra tx"}, 256'(0), 256'(u_uart.tx_count()));
            expect_equal({name, " rx left"}, 256'(0), 256'(u_uart.rx_left()));
            expect_equal({name, " bad rx"}, 256'(0), 256'(u_uart.bad_rx_reads));
            expect_equal({name, " bad tx"}, 256'(0), 256'(u_uart.bad_tx_writes));
        end
    endtask

    task automatic run_message(input string name, input logic [255:0] n,
                               input logic [255:0] d, input logic [255:0] enc);
        if (!aborted) begin
            send_message(n, d, enc);
            collect_result(name, mod_exp(enc, d, n));
            check_clean(name);
        end
    endtask

    task automatic test_reset_state();
        expect_equal("reset_state read", 256'(1), 256'(avm_read));
        expect_equal("reset_state address", 256'(avm_pkg::STATUS_ADDR), 256'(avm_address));
        expect_equal("reset_state write", 256'(0), 256'(avm_write));
    endtask

    task automatic test_single_message();
        u_uart.set_knobs(0, 0);
        run_message("single_message", N0, msg_d, msg_enc);
    endtask

    task automatic test_back_pressure();
        u_uart.set_knobs(40, 0);
        run_message("back_pressure", N0, msg_d, msg_enc);
    endtask

    task automatic test_status_gaps();
        u_uart.set_knobs(0, 50);
        run_message("status_gaps", N0, msg_d, msg_enc);
    endtask

    task automatic test_two_messages();
        logic [255:0] d0;
        logic [255:0] e0;
        logic [255:0] d1;
        logic [255:0] e1;
        d0 = random_below_top();
        e0 = random_below_top();
        d1 = random_below_top();
        e1 = random_below_top();
        u_uart.set_knobs(20, 20);
        if (!aborted) begin
            send_message(N0, d0, e0);
            send_message(N1, d1, e1); // Queued before the first result comes back.
            collect_result("two_messages first", mod_exp(e0, d0, N0));
            collect_result("two_messages second", mod_exp(e1, d1, N1));
            check_clean("two_messages");
        end
    endtask

    task automatic test_unit_exponent();
        logic [255:0] enc;
        enc = random_below_top();
        u_uart.set_knobs(0, 0);
        if (!aborted) begin
            send_message(N1, 256'd1, enc);
            collect_result("unit_exponent", enc % N1);
            check_clean("unit_exponent");
        end
    endtask

    initial begin
        void'($urandom(32'h09da_4edf));
        avm_rst = 1'b1;
        errors  = 0;
        checks  = 0;
        aborted = 1'b0;
        msg_d   = random_below_top();
        msg_enc = random_below_top();
        repeat (3) @(posedge avm_clk);
        #2;
        avm_rst = 1'b0;
        test_reset_state();
        test_single_message();
        test_back_pressure();
        test_status_gaps();
        test_two_messages();
        test_unit_exponent();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_uart_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_model (
    input  logic        avm_clk,
    input  logic [4:0]  address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    logic [7:0]  rx_q[$];
    logic [7:0]  tx_q[$];
    int unsigned wait_pct;
    int unsigned gap_pct;
    int unsigned bad_rx_reads;  // RX reads not preceded by a status read with RX_OK.
    int unsigned bad_tx_writes; // TX writes not preceded by a status read with TX_OK.
    logic        rx_gate;
    logic        tx_gate;
    logic        rx_armed;
    logic        tx_armed;

    task automatic push_byte(input logic [7:0] b);
        rx_q.push_back(b);
    endtask

    task automatic take_byte(output logic [7:0] b);
        b = tx_q.pop_front();
    endtask

    task automatic set_knobs(input int unsigned wait_percent, input int unsigned gap_percent);
        wait_pct = wait_percent;
        gap_pct  = gap_percent;
    endtask

    function automatic int tx_count();
        return tx_q.size();
    endfunction

    function automatic int rx_left();
        return rx_q.size();
    endfunction

    function automatic logic chance(input int unsigned pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic logic [31:0] read_value();
        logic [31:0] v;
        v = '0;
        if (address == avm_pkg::STATUS_ADDR) begin
            v[avm_pkg::RX_OK_BIT] = rx_gate && (rx_q.size() != 0);
            v[avm_pkg::TX_OK_BIT] = tx_gate;
        end else if (address == avm_pkg::RX_ADDR && rx_q.size() != 0) begin
            v[7:0] = rx_q[0];
        end
        return v;
    endfunction

    initial begin
        readdata      = '0;
        waitrequest   = 1'b0;
        wait_pct      = 0;
        gap_pct       = 0;
        bad_rx_reads  = 0;
        bad_tx_writes = 0;
        rx_gate       = 1'b1;
        tx_gate       = 1'b1;
        rx_armed      = 1'b0;
        tx_armed      = 1'b0;
        forever begin
            @(posedge avm_clk);
            if ((read || write) && !waitrequest) begin
                if (read && address == avm_pkg::STATUS_ADDR) begin
                    rx_armed = readdata[avm_pkg::RX_OK_BIT];
                    tx_armed = readdata[avm_pkg::TX_OK_BIT];
                end else if (read && address == avm_pkg::RX_ADDR) begin
                    if (!rx_armed || rx_q.size() == 0) begin
                        bad_rx_reads++;
                    end else begin
                        void'(rx_q.pop_front());
                    end
                    rx_armed = 1'b0;
                end else if (write && address == avm_pkg::TX_ADDR) begin
                    if (!tx_armed) begin
                        bad_tx_writes++;
                    end
                    tx_q.push_back(writedata[7:0]);
                    tx_armed = 1'b0;
                end
            end
            #1;
            waitrequest = chance(wait_pct);
            rx_gate     = !chance(gap_pct);
            tx_gate     = !chance(gap_pct);
            readdata    = read_value(); // Address has settled by now.
        end
    end

endmodule

`default_nettype wire

// File: hw/avm_pkg.sv
`default_nettype none

package avm_pkg;

    // Serial port registers, word aligned.
    localparam logic [4:0] RX_ADDR     = 5'd0;
    localparam logic [4:0] TX_ADDR     = 5'd4;
    localparam logic [4:0] STATUS_ADDR = 5'd8;

    localparam int TX_OK_BIT = 6; // Transmitter can take a byte.
    localparam int RX_OK_BIT = 7; // Receiver holds a byte.

    typedef enum logic [2:0] {
        READ_READY,
        GET_N,
        GET_D,
        GET_ENC,
        WAIT_CORE,
        WRITE_READY,
        SEND
    } wrap_state_e;

    // Request side of an Avalon-MM master, held until waitrequest drops.
    typedef struct packed {
        logic [4:0] address;
        logic       read;
        logic       write;
    } avm_req_t;

endpackage

`default_nettype wire

// File: hw/rsa_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_core #(
    parameter int KEY_BITS = rsa_pkg::KEY_BITS_DEF
) (
    input  logic                  avm_clk,
    input  logic                  avm_rst,
    input  logic                  start,
    input  rsa_pkg::rsa_operands_t operands,
    output logic [KEY_BITS-1:0]   result,
    output logic                  done
);

    localparam int CW = $clog2(KEY_BITS + 1);

    rsa_pkg::core_state_e state;
    logic [CW-1:0]       round;
    logic [KEY_BITS-1:0] n;
    logic [KEY_BITS-1:0] d_sh;
    logic [KEY_BITS-1:0] m;
    logic [KEY_BITS-1:0] t;
    logic                prep_start;
    logic                prep_done;
    logic [KEY_BITS-1:0] prep_result;
    logic                mont_start;
    logic                m_done;
    logic                t_done;
    logic [KEY_BITS-1:0] m_result;
    logic [KEY_BITS-1:0] t_result;
    logic                round_done;

    assign n          = operands.n[KEY_BITS-1:0];
    assign round_done = m_done && t_done;
    assign result     = m;

    rsa_prep #(.KEY_BITS(KEY_BITS)) u_prep (
        .avm_clk(avm_clk), .avm_rst(avm_rst), .start(prep_start),
        .a(operands.a[KEY_BITS-1:0]), .n(n), .result(prep_result), .done(prep_done)
    );

    // m stays in the plain domain, t carries a^(2^i) in Montgomery form.
    rsa_mont #(.KEY_BITS(KEY_BITS)) u_mont_m (
        .avm_clk(avm_clk), .avm_rst(avm_rst), .start(mont_start),
        .x(m), .y(t), .n(n), .result(m_result), .done(m_done)
    );

    rsa_mont #(.KEY_BITS(KEY_BITS)) u_mont_t (
        .avm_clk(avm_clk), .avm_rst(avm_rst), .start(mont_start),
        .x(t), .y(t), .n(n), .result(t_result), .done(t_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= rsa_pkg::IDLE;
            round      <= '0;
            prep_start <= 1'b0;
            mont_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            prep_start <= 1'b0;
            mont_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                rsa_pkg::IDLE: begin
                    if (start) begin
                        prep_start <= 1'b1;
                        state      <= rsa_pkg::PREP;
                    end
                end
                rsa_pkg::PREP: begin
                    if (prep_done) begin
                        mont_start <= 1'b1;
                        round      <= '0;
                        state      <= rsa_pkg::ROUND;
                    end
                end
                rsa_pkg::ROUND: begin
                    if (round_done) begin
                        if (round == CW'(KEY_BITS - 1)) begin
                            state <= rsa_pkg::DONE;
                        end else begin
                            round      <= round + 1'b1;
                            mont_start <= 1'b1;
                        end
                    end
                end
                default: begin
                    done  <= 1'b1; // Result holds m, which is final here.
                    state <= rsa_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            rsa_pkg::IDLE: begin
                if (start) begin
                    d_sh <= operands.d[KEY_BITS-1:0];
                end
            end
            rsa_pkg::PREP: begin
                if (prep_done) begin
                    m <= KEY_BITS'(1);
                    t <= prep_result;
                end
            end
            rsa_pkg::ROUND: begin
                if (round_done) begin
                    t    <= t_result;
                    d_sh <= d_sh >> 1; // Exponent bits are taken LSB first.
                    if (d_sh[0]) begin
                        m <= m_result;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rsa_mont.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_mont #(
    parameter int KEY_BITS = rsa_pkg::KEY_BITS_DEF
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [KEY_BITS-1:0] x,
    input  logic [KEY_BITS-1:0] y,
    input  logic [KEY_BITS-1:0] n,
    output logic [KEY_BITS-1:0] result,
    output logic                done
);

    localparam int CW = $clog2(KEY_BITS + 1);

    logic [KEY_BITS-1:0] x_sh;
    logic [KEY_BITS:0]   s;
    logic [KEY_BITS+1:0] sum_y;
    logic [KEY_BITS+1:0] sum_n;
    logic [KEY_BITS:0]   s_next;
    logic [KEY_BITS:0]   s_red;
    logic [CW-1:0]       cnt;
    logic                busy;
    logic                last;

    // The partial sum stays below 2n, so y and n together need two extra bits.
    assign sum_y  = {1'b0, s} + (x_sh[0] ? {2'b00, y} : '0);
    assign sum_n  = sum_y + (sum_y[0] ? {2'b00, n} : '0);
    assign s_next = sum_n[KEY_BITS+1:1];
    assign s_red  = (s_next >= {1'b0, n}) ? s_next - {1'b0, n} : s_next;
    assign last   = (cnt == CW'(KEY_BITS - 1));
    assign result = s[KEY_BITS-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // y and n must stay stable while busy. Only x is consumed bit by bit.
    always_ff @(posedge avm_clk) begin
        if (start) begin
            x_sh <= x;
            s    <= '0;
        end else if (busy) begin
            x_sh <= x_sh >> 1;
            s    <= last ? s_red : s_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

    // Operand width used when the top level does not override KEY_BITS.
    localparam int KEY_BITS_DEF = 256;

    // Everything the core needs for one decryption, latched by the wrapper.
    typedef struct packed {
        logic [KEY_BITS_DEF-1:0] n; // Modulus, must be odd.
        logic [KEY_BITS_DEF-1:0] d; // Private exponent.
        logic [KEY_BITS_DEF-1:0] a; // Ciphertext, below n.
    } rsa_operands_t;

    typedef enum logic [1:0] {
        IDLE,
        PREP,  // Bringing the ciphertext into the Montgomery domain.
        ROUND, // One square and one conditional multiply per exponent bit.
        DONE
    } core_state_e;

endpackage

`default_nettype wire

// File: hw/rsa_prep.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_prep #(
    parameter int KEY_BITS = rsa_pkg::KEY_BITS_DEF
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [KEY_BITS-1:0] a,
    input  logic [KEY_BITS-1:0] n,
    output logic [KEY_BITS-1:0] result,
    output logic                done
);

    localparam int CW = $clog2(KEY_BITS + 1);

    logic [KEY_BITS-1:0] val;
    logic [CW-1:0]       cnt;
    logic                busy;
    logic [KEY_BITS:0]   dbl;
    logic [KEY_BITS:0]   dbl_red;

    assign dbl     = {val, 1'b0}; // Extra top bit keeps 2*val from overflowing.
    assign dbl_red = (dbl >= {1'b0, n}) ? dbl - {1'b0, n} : dbl;
    assign result  = val;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(KEY_BITS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            val <= a;
        end else if (busy) begin
            val <= dbl_red[KEY_BITS-1:0]; // Below n, so one subtraction is enough.
        end
    end

endmodule

`default_nettype wire

// File: hw/rsa_system.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_system #(
    parameter int KEY_BITS = rsa_pkg::KEY_BITS_DEF
) (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);

    rsa_pkg::rsa_operands_t operands;
    logic                   core_start;
    logic [KEY_BITS-1:0]    core_result;
    logic                   core_done;

    rsa_wrapper #(.KEY_BITS(KEY_BITS)) u_wrapper (
        .avm_clk    (avm_clk),
        .avm_rst    (avm_rst),
        .address    (avm_address),
        .read       (avm_read),
        .write      (avm_write),
        .readdata   (avm_readdata),
        .writedata  (avm_writedata),
        .waitrequest(avm_waitrequest),
        .operands   (operands),
        .core_start (core_start),
        .core_result(core_result),
        .core_done  (core_done)
    );

    rsa_core #(.KEY_BITS(KEY_BITS)) u_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (core_start),
        .operands(operands),
        .result  (core_result),
        .done    (core_done)
    );

endmodule

`default_nettype wire

// File: hw/rsa_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_wrapper #(
    parameter int KEY_BITS = rsa_pkg::KEY_BITS_DEF
) (
    input  logic                   avm_clk,
    input  logic                   avm_rst,
    output logic [4:0]             address,
    output logic                   read,
    output logic                   write,
    input  logic [31:0]            readdata,
    output logic [31:0]            writedata,
    input  logic                   waitrequest,
    output rsa_pkg::rsa_operands_t operands,
    output logic                   core_start,
    input  logic [KEY_BITS-1:0]    core_result,
    input  logic                   core_done
);

    localparam int BYTES = KEY_BITS / 8;
    localparam int CW    = $clog2(3 * BYTES + 1);
    localparam int FB    = rsa_pkg::KEY_BITS_DEF;

    localparam avm_pkg::avm_req_t STATUS_RD = '{avm_pkg::STATUS_ADDR, 1'b1, 1'b0};
    localparam avm_pkg::avm_req_t RX_RD     = '{avm_pkg::RX_ADDR, 1'b1, 1'b0};
    localparam avm_pkg::avm_req_t TX_WR     = '{avm_pkg::TX_ADDR, 1'b0, 1'b1};
    localparam avm_pkg::avm_req_t NO_REQ    = '{avm_pkg::STATUS_ADDR, 1'b0, 1'b0};

    avm_pkg::wrap_state_e state;
    avm_pkg::avm_req_t    req;
    logic [CW-1:0]        cnt;
    logic [KEY_BITS-1:0]  dec;
    logic [7:0]           rx_byte;
    logic                 xfer_done;
    logic                 last_in;
    logic                 last_out;

    assign address   = req.address;
    assign read      = req.read;
    assign write     = req.write;
    assign writedata = {24'd0, dec[KEY_BITS-9 -: 8]}; // Top byte of the result is never sent.
    assign rx_byte   = readdata[7:0];
    assign xfer_done = (req.read || req.write) && !waitrequest;
    assign last_in   = (cnt == CW'(3 * BYTES - 1));
    assign last_out  = (cnt == CW'(BYTES - 2));

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= avm_pkg::READ_READY;
            req        <= STATUS_RD;
            cnt        <= '0;
            core_start <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                avm_pkg::READ_READY: begin
                    if (xfer_done && readdata[avm_pkg::RX_OK_BIT]) begin
                        req <= RX_RD;
                        if (cnt < CW'(BYTES)) begin
                            state <= avm_pkg::GET_N;
                        end else if (cnt < CW'(2 * BYTES)) begin
                            state <= avm_pkg::GET_D;
                        end else begin
                            state <= avm_pkg::GET_ENC;
                        end
                    end
                end
                avm_pkg::GET_N, avm_pkg::GET_D, avm_pkg::GET_ENC: begin
                    if (xfer_done) begin
                        if (last_in) begin
                            req        <= NO_REQ; // Bus stays quiet while the core runs.
                            cnt        <= '0;
                            core_start <= 1'b1;
                            state      <= avm_pkg::WAIT_CORE;
                        end else begin
                            req   <= STATUS_RD;
                            cnt   <= cnt + 1'b1;
                            state <= avm_pkg::READ_READY;
                        end
                    end
                end
                avm_pkg::WAIT_CORE: begin
                    if (core_done) begin
                        req   <= STATUS_RD;
                        state <= avm_pkg::WRITE_READY;
                    end
                end
                avm_pkg::WRITE_READY: begin
                    if (xfer_done && readdata[avm_pkg::TX_OK_BIT]) begin
                        req   <= TX_WR;
                        state <= avm_pkg::SEND;
                    end
                end
                avm_pkg::SEND: begin
                    if (xfer_done) begin
                        req <= STATUS_RD;
                        if (last_out) begin
                            cnt   <= '0;
                            state <= avm_pkg::READ_READY; // Next message brings new keys.
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= avm_pkg::WRITE_READY;
                        end
                    end
                end
                default: begin
                    req   <= STATUS_RD;
                    state <= avm_pkg::READ_READY;
                end
            endcase
        end
    end

    // Operands arrive most significant byte first and are shifted in from the right.
    always_ff @(posedge avm_clk) begin
        if (xfer_done) begin
            case (state)
                avm_pkg::GET_N:   operands.n <= {operands.n[FB-9:0], rx_byte};
                avm_pkg::GET_D:   operands.d <= {operands.d[FB-9:0], rx_byte};
                avm_pkg::GET_ENC: operands.a <= {operands.a[FB-9:0], rx_byte};
                avm_pkg::SEND:    dec <= dec << 8;
                default: ;
            endcase
        end
        if (state == avm_pkg::WAIT_CORE && core_done) begin
            dec <= core_result;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the RSA subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f compile.f --top-module tb_rsa_system \
        --Mdir obj_dir -o tb_rsa_system; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_rsa_system > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
